// File: flist.f
design/dphy_pkg.sv
design/capture_pkg.sv
design/dphy_byte_align.sv
design/lane_word_packer.sv
design/buffer_write_arbiter.sv
design/capture_buffer.sv
design/dphy_capture_top.sv
verification/dphy_capture_properties.sv
verification/tb_dphy_capture.sv

// File: Makefile
BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module tb_dphy_capture -Mdir $(BUILD) -o sim_tb

run: compile
	./$(BUILD)/sim_tb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/tb_dphy_capture.sv
`timescale 1ns/1ps

module tb_dphy_capture;

  localparam int LANES          = 2;
  localparam int REGION_AW      = 6;
  localparam int WORDS          = 8;   // words per burst
  localparam int CLK_PERIOD     = 8;
  localparam int MAX_STREAM     = 48;
  localparam int NUM_BURSTS     = 10;
  localparam int TIMEOUT_CYCLES = NUM_BURSTS * (2 + MAX_STREAM + 2 * (WORDS + 2)) + 200;

  logic                        clk_i;
  logic                        rst_i;
  dphy_pkg::byte_t [LANES-1:0] unaligned_byte_i;
  logic [LANES-1:0]            hs_data_valid_i;
  logic [LANES-1:0]            reset_align_i;
  capture_pkg::addr_t          rd_addr_i;
  capture_pkg::word_t          rd_data_o;
  logic [LANES-1:0]            locked_o;
  logic [LANES-1:0]            overflow_o;

  logic [7:0]         payload [LANES][4*WORDS];
  logic [7:0]         stream  [LANES][MAX_STREAM];
  int                 slen    [LANES];
  int                 lock_lo [LANES];  // first cycle with locked_o high
  int                 lock_hi [LANES];
  logic               rd_check;
  capture_pkg::word_t rd_expect;
  logic               chk_q;
  capture_pkg::word_t exp_q;
  capture_pkg::addr_t addr_q;
  int                 data_errs;
  int                 lock_errs;
  int                 ovf_errs;

  dphy_capture_top #(.LANES(LANES), .REGION_AW(REGION_AW)) i_dphy_capture_top
  (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .unaligned_byte_i (unaligned_byte_i),
    .hs_data_valid_i  (hs_data_valid_i),
    .reset_align_i    (reset_align_i),
    .rd_addr_i        (rd_addr_i),
    .rd_data_o        (rd_data_o),
    .locked_o         (locked_o),
    .overflow_o       (overflow_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // little endian, byte 4*idx in the low bits
  function automatic capture_pkg::word_t expected_word(input int lane, input int idx);
    expected_word = {payload[lane][4*idx+3], payload[lane][4*idx+2],
                     payload[lane][4*idx+1], payload[lane][4*idx]};
  endfunction

  // zero idle bits, sync byte, payload, all sent lsb first
  task automatic build_lane(input int lane, input int off);
    logic [383:0] bits;
    int           idle;
    int           s;
    bits = '0;
    idle = 1 + ($urandom % 3);
    s    = 8 * idle + off;
    bits[s +: 8] = dphy_pkg::SYNC_PATTERN;
    for (int k = 0; k < 4 * WORDS; k++)
    begin
      payload[lane][k] = 8'($urandom);
      bits[s + 8 + 8 * k +: 8] = payload[lane][k];
    end
    slen[lane] = idle + 3 + 4 * WORDS;  // padding covers the offset spill and the two-byte delay
    for (int j = 0; j < slen[lane]; j++)
      stream[lane][j] = bits[8 * j +: 8];
    lock_lo[lane] = idle + 4;
    lock_hi[lane] = idle + 3 + 4 * WORDS;
  endtask

  task automatic clear_lane(input int lane);
    slen[lane]    = 0;
    lock_lo[lane] = 1;
    lock_hi[lane] = 0;
  endtask

  task automatic realign(input logic [LANES-1:0] lanes);
    @(posedge clk_i);
    reset_align_i <= lanes;
    @(posedge clk_i);
    reset_align_i <= '0;
  endtask

  task automatic run_burst();
    int last;
    last = ((slen[0] > slen[1]) ? slen[0] : slen[1]) + 3;
    for (int c = 0; c < last; c++)
    begin
      @(posedge clk_i);
      for (int l = 0; l < LANES; l++)
      begin
        unaligned_byte_i[l] <= (c < slen[l]) ? stream[l][c] : 8'h00;
        hs_data_valid_i[l]  <= (c < slen[l]);
      end
      @(negedge clk_i);
      for (int l = 0; l < LANES; l++)
      begin
        if (locked_o[l] !== (c >= lock_lo[l] && c <= lock_hi[l]))
        begin
          lock_errs++;
          $display("Fail: %0t locked_o[%0d] expected %b got %b", $time, l,
                   (c >= lock_lo[l] && c <= lock_hi[l]), locked_o[l]);
        end
      end
      if (overflow_o !== '0)
      begin
        ovf_errs++;
        $display("Fail: %0t overflow_o expected 00 got %b", $time, overflow_o);
      end
    end
  endtask

  task automatic check_region(input int lane);
    for (int idx = 0; idx < WORDS; idx++)
    begin
      @(posedge clk_i);
      rd_addr_i <= capture_pkg::addr_t'((lane << REGION_AW) | idx);
      rd_check  <= 1'b1;
      rd_expect <= expected_word(lane, idx);
    end
    @(posedge clk_i);
    rd_check <= 1'b0;
    @(posedge clk_i);
  endtask

  always @(posedge clk_i)
  begin
    chk_q  <= rd_check;
    exp_q  <= rd_expect;
    addr_q <= rd_addr_i;
  end

  always @(negedge clk_i)
  begin
    if (chk_q && rd_data_o !== exp_q)
    begin
      data_errs++;
      $display("Fail: %0t rd_data_o[%h] expected %h got %h", $time, addr_q, exp_q, rd_data_o);
    end
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not reach its end in time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    int off;
    rst_i            = 1'b1;
    unaligned_byte_i = '0;
    hs_data_valid_i  = '0;
    reset_align_i    = '0;
    rd_addr_i        = '0;
    rd_check         = 1'b0;
    rd_expect        = '0;
    data_errs        = 0;
    lock_errs        = 0;
    ovf_errs         = 0;
    void'($urandom(32'h7deb_562c));
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    for (off = 0; off < 8; off++)  // lane 0 at every bit offset
    begin
      realign(2'b01);
      build_lane(0, off);
      clear_lane(1);
      run_burst();
      check_region(0);
    end
    off = int'($urandom % 8);
    realign(2'b11);
    build_lane(0, off);
    build_lane(1, (off + 1 + int'($urandom % 7)) % 8);
    run_burst();
    check_region(0);
    check_region(1);
    realign(2'b01);  // re-lock lane 0 at another offset
    build_lane(0, (off + 4) % 8);
    clear_lane(1);
    run_burst();
    check_region(0);
    $display("errors: data %0d lock %0d overflow %0d", data_errs, lock_errs, ovf_errs);
    if (data_errs + lock_errs + ovf_errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: verification/dphy_capture_properties.sv
`timescale 1ns/1ps

module dphy_capture_properties
#(
  parameter int LANES = 2
)
(
  input logic                             clk_i,
  input logic                             rst_i,
  input capture_pkg::wr_req_t [LANES-1:0] req_i,
  input logic [LANES-1:0]                 gnt_i
);

  a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_i))
    else $error("more than one lane granted in the same cycle");

  for (genvar g = 0; g < LANES; g++)
  begin : g_lane
    a_gnt_valid: assert property (@(posedge clk_i) disable iff (rst_i)
      gnt_i[g] |-> req_i[g].valid)
      else $error("lane %0d granted without a valid request", g);

    // a waiting request keeps its word and address
    a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i[g].valid && !gnt_i[g] |=>
        req_i[g].valid && $stable(req_i[g].addr) && $stable(req_i[g].data))
      else $error("lane %0d request changed before its grant", g);
  end

endmodule

bind buffer_write_arbiter dphy_capture_properties #(.LANES(LANES)) i_properties
(
  .clk_i (clk_i),
  .rst_i (rst_i),
  .req_i (req_i),
  .gnt_i (gnt_o)
);

// File: design/dphy_capture_top.sv
`timescale 1ns/1ps

module dphy_capture_top
#(
  parameter int LANES     = 2,
  parameter int REGION_AW = 6
)
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  dphy_pkg::byte_t [LANES-1:0] unaligned_byte_i,
  input  logic [LANES-1:0]            hs_data_valid_i,
  input  logic [LANES-1:0]            reset_align_i,
  input  capture_pkg::addr_t          rd_addr_i,
  output capture_pkg::word_t          rd_data_o,
  output logic [LANES-1:0]            locked_o,
  output logic [LANES-1:0]            overflow_o
);

  dphy_pkg::byte_t [LANES-1:0]      aligned_byte;
  capture_pkg::wr_req_t [LANES-1:0] lane_req;
  logic [LANES-1:0]                 lane_gnt;
  capture_pkg::wr_req_t             buf_wr;

  for (genvar g = 0; g < LANES; g++)
  begin : g_lane
    dphy_byte_align i_byte_align
    (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .unaligned_byte_i (unaligned_byte_i[g]),
      .reset_align_i    (reset_align_i[g]),
      .hs_data_valid_i  (hs_data_valid_i[g]),
      .valid_o          (locked_o[g]),
      .aligned_byte_o   (aligned_byte[g])
    );

    lane_word_packer
    #(
      .LANE_ID   (g),
      .REGION_AW (REGION_AW)
    ) i_word_packer
    (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .byte_valid_i (locked_o[g]),  // aligner valid doubles as the lock flag
      .byte_i       (aligned_byte[g]),
      .req_o        (lane_req[g]),
      .gnt_i        (lane_gnt[g]),
      .overflow_o   (overflow_o[g])
    );
  end

  buffer_write_arbiter
  #(
    .LANES (LANES)
  ) i_write_arbiter
  (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (lane_req),
    .gnt_o (lane_gnt),
    .wr_o  (buf_wr)
  );

  capture_buffer
  #(
    .REGION_AW (REGION_AW),
    .LANES     (LANES)
  ) i_capture_buffer
  (
    .clk_i     (clk_i),
    .wr_i      (buf_wr),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

// File: design/capture_buffer.sv
`timescale 1ns/1ps

module capture_buffer
#(
  parameter int REGION_AW = 6,
  parameter int LANES     = 2
)
(
  input  logic                 clk_i,
  input  capture_pkg::wr_req_t wr_i,
  input  capture_pkg::addr_t   rd_addr_i,
  output capture_pkg::word_t   rd_data_o
);

  localparam int DEPTH = LANES << REGION_AW;
  localparam int AW    = $clog2(DEPTH);

  capture_pkg::word_t mem [DEPTH];

  logic [AW-1:0] wr_idx;
  logic [AW-1:0] rd_idx;

  assign wr_idx = wr_i.addr[AW-1:0];
  assign rd_idx = rd_addr_i[AW-1:0];

  always_ff @(posedge clk_i)
  begin
    if (wr_i.valid)
      mem[wr_idx] <= wr_i.data;
  end

  // one cycle read latency, a write is seen on the following cycle
  always_ff @(posedge clk_i)
  begin
    rd_data_o <= mem[rd_idx];
  end

endmodule

// File: design/buffer_write_arbiter.sv
`timescale 1ns/1ps

module buffer_write_arbiter
#(
  parameter int LANES = 2
)
(
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  capture_pkg::wr_req_t [LANES-1:0] req_i,
  output logic [LANES-1:0]                 gnt_o,
  output capture_pkg::wr_req_t             wr_o
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] rr_ptr;
  logic [PTR_W-1:0] winner;
  logic             found;

  // first valid requester at or after the pointer
  always_comb
  begin
    int cand;
    winner = rr_ptr;
    found  = 1'b0;
    for (int k = LANES - 1; k >= 0; k--)
    begin
      cand = (int'(rr_ptr) + k) % LANES;
      if (req_i[cand].valid)
      begin
        winner = PTR_W'(cand);
        found  = 1'b1;
      end
    end
  end

  always_comb
  begin
    gnt_o = '0;
    wr_o  = '0;
    if (found)
    begin
      gnt_o[winner] = 1'b1;
      wr_o          = req_i[winner];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      rr_ptr <= '0;
    else if (found)
      rr_ptr <= (int'(winner) == LANES - 1) ? '0 : winner + PTR_W'(1);  // skip past the winner
  end

endmodule

// File: design/lane_word_packer.sv
`timescale 1ns/1ps

module lane_word_packer
#(
  parameter int LANE_ID   = 0,
  parameter int REGION_AW = 6
)
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 byte_valid_i,
  input  dphy_pkg::byte_t      byte_i,
  output capture_pkg::wr_req_t req_o,
  input  logic                 gnt_i,
  output logic                 overflow_o
);

  localparam capture_pkg::addr_t REGION_BASE = capture_pkg::addr_t'(LANE_ID << REGION_AW);

  logic [1:0]           byte_cnt;
  logic [REGION_AW-1:0] word_idx;
  capture_pkg::word_t   word_q;
  capture_pkg::word_t   word_next;
  logic                 word_done;
  logic                 slot_free;
  logic                 req_valid;
  capture_pkg::addr_t   req_addr;
  capture_pkg::word_t   req_data;

  // incoming byte lands in its little-endian lane of the word
  always_comb
  begin
    word_next = word_q;
    word_next[{byte_cnt, 3'b000} +: 8] = byte_i;
  end

  assign word_done = byte_valid_i && (byte_cnt == 2'd3);
  assign slot_free = !req_valid || gnt_i;  // slot empties on the grant edge

  always_ff @(posedge clk_i)
  begin
    if (byte_valid_i)
      word_q <= word_next;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      byte_cnt <= '0;
      word_idx <= '0;
    end
    else if (!byte_valid_i)
    begin
      byte_cnt <= '0;  // next burst starts at word 0
      word_idx <= '0;
    end
    else
    begin
      byte_cnt <= byte_cnt + 2'd1;
      if (word_done)
        word_idx <= word_idx + REGION_AW'(1);  // wraps inside the region
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      req_valid <= 1'b0;
    else if (word_done && slot_free)
      req_valid <= 1'b1;
    else if (gnt_i)
      req_valid <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (word_done && slot_free)
    begin
      req_addr <= REGION_BASE | capture_pkg::addr_t'(word_idx);
      req_data <= word_next;
    end
  end

  // word dropped while the slot still waits for its grant
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      overflow_o <= 1'b0;
    else if (word_done && !slot_free)
      overflow_o <= 1'b1;
  end

  assign req_o.valid = req_valid;
  assign req_o.addr  = req_addr;
  assign req_o.data  = req_data;

endmodule

// File: design/dphy_byte_align.sv
`timescale 1ns/1ps

module dphy_byte_align
(
  input  logic            clk_i,
  input  logic            rst_i,
  input  dphy_pkg::byte_t unaligned_byte_i,
  input  logic            reset_align_i,
  input  logic            hs_data_valid_i,
  output logic            valid_o,
  output dphy_pkg::byte_t aligned_byte_o
);

  dphy_pkg::byte_t   byte_d1;
  dphy_pkg::byte_t   byte_d2;
  dphy_pkg::window_t window;
  dphy_pkg::window_t shifted;
  dphy_pkg::shift_t  sync_offset;
  dphy_pkg::shift_t  align_shift;
  logic              found_sync;
  logic              locked;
  logic              lock_set;

  always_ff @(posedge clk_i)
  begin
    byte_d1 <= unaligned_byte_i;
    byte_d2 <= byte_d1;
  end

  assign window = {byte_d1, byte_d2};

  // search all bit offsets, the lowest matching one wins
  always_comb
  begin
    sync_offset = '0;
    found_sync  = 1'b0;
    for (int i = dphy_pkg::BYTE_W - 1; i >= 0; i--)
    begin
      if (hs_data_valid_i && window[i +: dphy_pkg::BYTE_W] == dphy_pkg::SYNC_PATTERN)
      begin
        sync_offset = dphy_pkg::shift_t'(i);
        found_sync  = 1'b1;
      end
    end
  end

  assign lock_set = !locked && found_sync && !reset_align_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      locked <= 1'b0;
    else if (reset_align_i)
      locked <= 1'b0;  // start a new search
    else if (lock_set)
      locked <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (lock_set)
      align_shift <= sync_offset;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_o <= 1'b0;
    else if (reset_align_i || !hs_data_valid_i)
      valid_o <= 1'b0;
    else
      valid_o <= locked;
  end

  assign shifted = window >> align_shift;

  always_ff @(posedge clk_i)
  begin
    aligned_byte_o <= shifted[dphy_pkg::BYTE_W-1:0];  // byte after the sync byte comes first
  end

endmodule

// File: design/capture_pkg.sv
package capture_pkg;

  localparam int WORD_W = 32;
  localparam int ADDR_W = 8;

  typedef logic [WORD_W-1:0] word_t;  // four lane bytes, little endian

  // upper bits pick the lane region, lower bits the word inside it
  typedef logic [ADDR_W-1:0] addr_t;

  typedef struct packed
  {
    logic  valid;
    addr_t addr;
    word_t data;
  } wr_req_t;

endpackage

// File: design/dphy_pkg.sv
package dphy_pkg;

  localparam int BYTE_W = 8;

  // one deserialized lane byte, bit 0 arrived first
  typedef logic [BYTE_W-1:0] byte_t;

  typedef logic [2*BYTE_W-1:0] window_t;  // two consecutive bytes, older one in the low half

  typedef logic [2:0] shift_t;            // bit offset of the sync byte inside the window

  localparam byte_t SYNC_PATTERN = 8'b10111000;  // hs sync byte

endpackage
